// File: hw/rob_macros.svh
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// data word width
`define XLEN 32

// architectural register index width
`define REG_ADDR_W 5

// tag 0 is reserved, so 4 bits give 15 usable entries
`define ROB_TAG_W 4

`define ROB_ENTRIES 15

`endif

// File: hw/rob_pkg.sv
`default_nettype none
`include "rob_macros.svh"

package rob_pkg;

    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    typedef logic [`XLEN-1:0] xdata_t;

    // 0 means no producer
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    typedef logic [`XLEN-1:0] pc_t;

    // supplied by decode, kept per entry
    typedef enum logic [1:0] {
        KIND_ALU    = 2'd0,
        KIND_BRANCH = 2'd1,
        KIND_LOAD   = 2'd2,
        KIND_STORE  = 2'd3
    } instr_kind_t;

endpackage

`default_nettype wire

// File: hw/rob.sv
`timescale 1ns/1ps
`default_nettype none
`include "rob_macros.svh"

module rob
    import rob_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,

    input  wire              alloc_en,
    input  wire instr_kind_t alloc_kind,
    input  wire reg_idx_t    alloc_rd,
    input  wire              alloc_pred_taken,
    output logic             full,
    output rob_tag_t         alloc_tag,

    input  wire              ex_en,
    input  wire rob_tag_t    ex_tag,
    input  wire xdata_t      ex_data,
    input  wire              ex_taken,
    input  wire pc_t         ex_target,

    input  wire              ld_en,
    input  wire rob_tag_t    ld_tag,
    input  wire xdata_t      ld_data,

    output logic             commit_en,
    output reg_idx_t         commit_rd,
    output rob_tag_t         commit_tag,
    output xdata_t           commit_data,

    output logic             store_release_en,
    output rob_tag_t         store_release_tag,

    output logic             flush,
    output pc_t              redirect_pc,

    input  wire rob_tag_t    rd_tag_a,
    input  wire rob_tag_t    rd_tag_b,
    output logic             fwd_done_a,
    output xdata_t           fwd_data_a,
    output logic             fwd_done_b,
    output xdata_t           fwd_data_b
);

    // slot 0 stays empty so a tag indexes directly
    logic [`ROB_ENTRIES:0] occupied;
    logic [`ROB_ENTRIES:0] done;

    instr_kind_t kind   [0:`ROB_ENTRIES];
    reg_idx_t    rd     [0:`ROB_ENTRIES];
    xdata_t      data   [0:`ROB_ENTRIES];
    logic        pred   [0:`ROB_ENTRIES];
    logic        taken  [0:`ROB_ENTRIES];
    pc_t         target [0:`ROB_ENTRIES];

    rob_tag_t rd_ptr;
    rob_tag_t wr_ptr;

    logic alloc_ok;
    logic ex_ok;
    logic ld_ok;
    logic head_valid;
    logic head_store;
    logic head_mispred;

    // wraps from the last entry back to 1
    function automatic rob_tag_t next_ptr(input rob_tag_t p);
        next_ptr = (p == rob_tag_t'(`ROB_ENTRIES)) ? rob_tag_t'(1) : p + rob_tag_t'(1);
    endfunction

    // no allocation during the flush cycle
    assign full      = occupied[wr_ptr] | flush;
    assign alloc_tag = wr_ptr;
    assign alloc_ok  = alloc_en & ~full;

    // late or repeated completions are dropped
    assign ex_ok = ex_en & occupied[ex_tag] & ~done[ex_tag] & ~flush;
    assign ld_ok = ld_en & occupied[ld_tag] & ~done[ld_tag] & ~flush;

    assign head_valid   = occupied[rd_ptr] & done[rd_ptr] & ~flush;
    assign head_store   = (kind[rd_ptr] == KIND_STORE);
    assign head_mispred = (kind[rd_ptr] == KIND_BRANCH) && (pred[rd_ptr] != taken[rd_ptr]);

    assign commit_en   = head_valid & ~head_store;
    assign commit_rd   = rd[rd_ptr];
    assign commit_tag  = rd_ptr;
    assign commit_data = data[rd_ptr];

    assign store_release_en  = head_valid & head_store;
    assign store_release_tag = rd_ptr;

    assign fwd_done_a = occupied[rd_tag_a] & done[rd_tag_a];
    assign fwd_data_a = data[rd_tag_a];
    assign fwd_done_b = occupied[rd_tag_b] & done[rd_tag_b];
    assign fwd_data_b = data[rd_tag_b];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied <= '0;
            done     <= '0;
            rd_ptr   <= rob_tag_t'(1);
            wr_ptr   <= rob_tag_t'(1);
            flush    <= 1'b0;
        end else if (flush) begin
            // drop everything younger than the mispredicted branch
            occupied <= '0;
            rd_ptr   <= rob_tag_t'(1);
            wr_ptr   <= rob_tag_t'(1);
            flush    <= 1'b0;
        end else begin
            flush <= commit_en & head_mispred;
            if (alloc_ok) begin
                occupied[wr_ptr] <= 1'b1;
                done[wr_ptr]     <= 1'b0;
                wr_ptr           <= next_ptr(wr_ptr);
            end
            if (ex_ok) begin
                done[ex_tag] <= 1'b1;
            end
            if (ld_ok) begin
                done[ld_tag] <= 1'b1;
            end
            if (head_valid) begin
                occupied[rd_ptr] <= 1'b0;
                rd_ptr           <= next_ptr(rd_ptr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_ok) begin
            kind[wr_ptr] <= alloc_kind;
            rd[wr_ptr]   <= alloc_rd;
            pred[wr_ptr] <= alloc_pred_taken;
        end
        if (ex_ok) begin
            data[ex_tag]   <= ex_data;
            taken[ex_tag]  <= ex_taken;
            target[ex_tag] <= ex_target;
        end
        if (ld_ok) begin
            data[ld_tag] <= ld_data;
        end
        // held until the next mispredict
        if (commit_en && head_mispred) begin
            redirect_pc <= target[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: hw/rename_table.sv
`timescale 1ns/1ps
`default_nettype none

module rename_table
    import rob_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,

    input  wire           alloc_set,
    input  wire reg_idx_t alloc_rd,
    input  wire rob_tag_t alloc_tag,

    input  wire           commit_en,
    input  wire reg_idx_t commit_rd,
    input  wire rob_tag_t commit_tag,

    input  wire           flush,

    input  wire reg_idx_t rs1,
    input  wire reg_idx_t rs2,
    output logic          busy1,
    output rob_tag_t      tag1,
    output logic          busy2,
    output rob_tag_t      tag2
);

    logic [31:0] busy;
    rob_tag_t    tags [0:31];

    assign busy1 = busy[rs1];
    assign busy2 = busy[rs2];

    // no producer reads as tag 0
    assign tag1 = busy[rs1] ? tags[rs1] : '0;
    assign tag2 = busy[rs2] ? tags[rs2] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else if (flush) begin
            busy <= '0;
        end else begin
            // only the youngest producer may clear its register
            if (commit_en && tags[commit_rd] == commit_tag) begin
                busy[commit_rd] <= 1'b0;
            end
            // a new producer wins over a same-cycle commit
            if (alloc_set) begin
                busy[alloc_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_set) begin
            tags[alloc_rd] <= alloc_tag;
        end
    end

endmodule

`default_nettype wire

// File: hw/arch_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module arch_regfile
    import rob_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,

    input  wire           we,
    input  wire reg_idx_t wr_idx,
    input  wire xdata_t   wr_data,

    input  wire reg_idx_t rs1,
    input  wire reg_idx_t rs2,
    output xdata_t        rdata1,
    output xdata_t        rdata2
);

    // x0 has no storage
    xdata_t regs [1:31];

    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/rob_sys_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_sys_top
    import rob_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,

    input  wire              alloc_en,
    input  wire instr_kind_t alloc_kind,
    input  wire reg_idx_t    alloc_rd,
    input  wire              alloc_pred_taken,
    output logic             full,
    output rob_tag_t         alloc_tag,

    input  wire              ex_en,
    input  wire rob_tag_t    ex_tag,
    input  wire xdata_t      ex_data,
    input  wire              ex_taken,
    input  wire pc_t         ex_target,

    input  wire              ld_en,
    input  wire rob_tag_t    ld_tag,
    input  wire xdata_t      ld_data,

    output logic             commit_en,
    output reg_idx_t         commit_rd,
    output rob_tag_t         commit_tag,
    output xdata_t           commit_data,

    output logic             store_release_en,
    output rob_tag_t         store_release_tag,

    output logic             flush,
    output pc_t              redirect_pc,

    input  wire reg_idx_t    rs1,
    input  wire reg_idx_t    rs2,
    output xdata_t           op1_val,
    output logic             op1_busy,
    output rob_tag_t         op1_tag,
    output logic             op1_ready,
    output xdata_t           op1_data,
    output xdata_t           op2_val,
    output logic             op2_busy,
    output rob_tag_t         op2_tag,
    output logic             op2_ready,
    output xdata_t           op2_data
);

    logic alloc_set;

    // accepted allocation that names a destination register
    assign alloc_set = alloc_en & ~full & (alloc_kind != KIND_STORE)
                     & (alloc_kind != KIND_BRANCH) & (alloc_rd != '0);

    rob u_rob (
        .clk               (clk),
        .rst_n             (rst_n),
        .alloc_en          (alloc_en),
        .alloc_kind        (alloc_kind),
        .alloc_rd          (alloc_rd),
        .alloc_pred_taken  (alloc_pred_taken),
        .full              (full),
        .alloc_tag         (alloc_tag),
        .ex_en             (ex_en),
        .ex_tag            (ex_tag),
        .ex_data           (ex_data),
        .ex_taken          (ex_taken),
        .ex_target         (ex_target),
        .ld_en             (ld_en),
        .ld_tag            (ld_tag),
        .ld_data           (ld_data),
        .commit_en         (commit_en),
        .commit_rd         (commit_rd),
        .commit_tag        (commit_tag),
        .commit_data       (commit_data),
        .store_release_en  (store_release_en),
        .store_release_tag (store_release_tag),
        .flush             (flush),
        .redirect_pc       (redirect_pc),
        .rd_tag_a          (op1_tag),
        .rd_tag_b          (op2_tag),
        .fwd_done_a        (op1_ready),
        .fwd_data_a        (op1_data),
        .fwd_done_b        (op2_ready),
        .fwd_data_b        (op2_data)
    );

    rename_table u_rename (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_set  (alloc_set),
        .alloc_rd   (alloc_rd),
        .alloc_tag  (alloc_tag),
        .commit_en  (commit_en),
        .commit_rd  (commit_rd),
        .commit_tag (commit_tag),
        .flush      (flush),
        .rs1        (rs1),
        .rs2        (rs2),
        .busy1      (op1_busy),
        .tag1       (op1_tag),
        .busy2      (op2_busy),
        .tag2       (op2_tag)
    );

    arch_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (commit_en),
        .wr_idx  (commit_rd),
        .wr_data (commit_data),
        .rs1     (rs1),
        .rs2     (rs2),
        .rdata1  (op1_val),
        .rdata2  (op2_val)
    );

endmodule

`default_nettype wire

// File: sim/rob_sys_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "rob_macros.svh"

module rob_sys_tb
    import rob_pkg::*;
();

    localparam logic [31:0] SEED = 32'h3a03f696;
    localparam int N_OPS = 400;
    localparam int CYCLE_LIMIT = 40 * N_OPS;
    localparam int ENTRIES = `ROB_ENTRIES;

    logic        clk;
    logic        rst_n;
    logic        alloc_en;
    instr_kind_t alloc_kind;
    reg_idx_t    alloc_rd;
    logic        alloc_pred_taken;
    logic        ex_en;
    rob_tag_t    ex_tag;
    xdata_t      ex_data;
    logic        ex_taken;
    pc_t         ex_target;
    logic        ld_en;
    rob_tag_t    ld_tag;
    xdata_t      ld_data;
    reg_idx_t    rs1;
    reg_idx_t    rs2;

    logic     full;
    rob_tag_t alloc_tag;
    logic     commit_en;
    reg_idx_t commit_rd;
    rob_tag_t commit_tag;
    xdata_t   commit_data;
    logic     store_release_en;
    rob_tag_t store_release_tag;
    logic     flush;
    pc_t      redirect_pc;
    xdata_t   op1_val;
    logic     op1_busy;
    rob_tag_t op1_tag;
    logic     op1_ready;
    xdata_t   op1_data;
    xdata_t   op2_val;
    logic     op2_busy;
    rob_tag_t op2_tag;
    logic     op2_ready;
    xdata_t   op2_data;

    // reference model state, indexed by tag
    logic        m_occ    [0:ENTRIES];
    logic        m_done   [0:ENTRIES];
    instr_kind_t m_kind   [0:ENTRIES];
    reg_idx_t    m_rd     [0:ENTRIES];
    xdata_t      m_data   [0:ENTRIES];
    logic        m_pred   [0:ENTRIES];
    logic        m_taken  [0:ENTRIES];
    pc_t         m_target [0:ENTRIES];
    rob_tag_t    alloc_q  [$];
    rob_tag_t    m_wr;
    logic        m_flush;
    pc_t         m_redirect;
    xdata_t      shadow   [0:31];
    logic        ren_busy [0:31];
    rob_tag_t    ren_tag  [0:31];

    logic [31:0] lfsr;
    int errors;
    int cycles;
    int retired;
    int stores;
    int flushes;
    int full_cycles;

    rob_sys_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h (cycle %0d)", name, exp, act, cycles);
        end
    endtask

    task automatic check_operand(input string name, input reg_idx_t rs, input xdata_t val,
                                 input logic busy, input rob_tag_t tag, input logic ready,
                                 input xdata_t data);
        logic exp_ready;
        expect_eq({name, "_val"}, shadow[rs], val);
        expect_eq({name, "_busy"}, 32'(ren_busy[rs]), 32'(busy));
        if (ren_busy[rs]) begin
            expect_eq({name, "_tag"}, 32'(ren_tag[rs]), 32'(tag));
            exp_ready = m_occ[ren_tag[rs]] & m_done[ren_tag[rs]];
            expect_eq({name, "_ready"}, 32'(exp_ready), 32'(ready));
            if (exp_ready) begin
                expect_eq({name, "_data"}, m_data[ren_tag[rs]], data);
            end
        end
    endtask

    task automatic check_outputs();
        logic hv;
        logic hs;
        rob_tag_t h;
        h  = (alloc_q.size() > 0) ? alloc_q[0] : rob_tag_t'(0);
        hv = (alloc_q.size() > 0) && m_done[h] && !m_flush;
        hs = hv && (m_kind[h] == KIND_STORE);
        expect_eq("full", 32'((alloc_q.size() == ENTRIES) || m_flush), 32'(full));
        if (full && !m_flush) begin
            full_cycles++;
        end
        if (!m_flush) begin
            expect_eq("alloc_tag", 32'(m_wr), 32'(alloc_tag));
        end
        expect_eq("commit_en", 32'(hv && !hs), 32'(commit_en));
        expect_eq("store_release_en", 32'(hs), 32'(store_release_en));
        expect_eq("flush", 32'(m_flush), 32'(flush));
        if (m_flush) begin
            expect_eq("redirect_pc", m_redirect, redirect_pc);
        end
        if (hv && !hs) begin
            expect_eq("commit_rd", 32'(m_rd[h]), 32'(commit_rd));
            expect_eq("commit_tag", 32'(h), 32'(commit_tag));
            expect_eq("commit_data", m_data[h], commit_data);
        end
        if (hs) begin
            expect_eq("store_release_tag", 32'(h), 32'(store_release_tag));
        end
        check_operand("op1", rs1, op1_val, op1_busy, op1_tag, op1_ready, op1_data);
        check_operand("op2", rs2, op2_val, op2_busy, op2_tag, op2_ready, op2_data);
    endtask

    // advances the model across the coming clock edge
    task automatic update_model();
        rob_tag_t h;
        logic was_full;
        logic mis;
        if (m_flush) begin
            for (int i = 0; i <= ENTRIES; i++) begin
                m_occ[i] = 1'b0;
            end
            for (int r = 0; r < 32; r++) begin
                ren_busy[r] = 1'b0;
            end
            alloc_q.delete();
            m_wr    = rob_tag_t'(1);
            m_flush = 1'b0;
            return;
        end
        was_full = (alloc_q.size() == ENTRIES);
        mis = 1'b0;
        if (alloc_q.size() > 0 && m_done[alloc_q[0]]) begin
            h = alloc_q.pop_front();
            m_occ[h] = 1'b0;
            retired++;
            if (m_kind[h] == KIND_STORE) begin
                stores++;
            end else begin
                if (m_rd[h] != 0) begin
                    shadow[m_rd[h]] = m_data[h];
                end
                if (ren_busy[m_rd[h]] && ren_tag[m_rd[h]] == h) begin
                    ren_busy[m_rd[h]] = 1'b0;
                end
                if (m_kind[h] == KIND_BRANCH && m_pred[h] != m_taken[h]) begin
                    mis = 1'b1;
                    m_redirect = m_target[h];
                end
            end
        end
        // repeated completions leave the entry alone
        if (ex_en && m_occ[ex_tag] && !m_done[ex_tag]) begin
            m_done[ex_tag]   = 1'b1;
            m_data[ex_tag]   = ex_data;
            m_taken[ex_tag]  = ex_taken;
            m_target[ex_tag] = ex_target;
        end
        if (ld_en && m_occ[ld_tag] && !m_done[ld_tag]) begin
            m_done[ld_tag] = 1'b1;
            m_data[ld_tag] = ld_data;
        end
        if (alloc_en && !was_full) begin
            m_occ[m_wr]  = 1'b1;
            m_done[m_wr] = 1'b0;
            m_kind[m_wr] = alloc_kind;
            m_rd[m_wr]   = alloc_rd;
            m_pred[m_wr] = alloc_pred_taken;
            alloc_q.push_back(m_wr);
            if ((alloc_kind == KIND_ALU || alloc_kind == KIND_LOAD) && alloc_rd != 0) begin
                ren_busy[alloc_rd] = 1'b1;
                ren_tag[alloc_rd]  = m_wr;
            end
            m_wr = (m_wr == rob_tag_t'(ENTRIES)) ? rob_tag_t'(1) : m_wr + rob_tag_t'(1);
        end
        m_flush = mis;
        if (mis) begin
            flushes++;
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] v;
        int idx;
        rob_tag_t t;
        draw(2, v);
        alloc_en <= (v[1:0] != 2'd0);
        draw(2, v);
        alloc_kind <= instr_kind_t'(v[1:0]);
        draw(5, v);
        alloc_rd <= reg_idx_t'(v);
        draw(1, v);
        alloc_pred_taken <= v[0];
        ex_en <= 1'b0;
        ld_en <= 1'b0;
        draw(1, v);
        // the picked entry may already be done
        if (v[0] && alloc_q.size() > 0 && !m_flush) begin
            draw(4, v);
            idx = int'(v) % alloc_q.size();
            t = alloc_q[idx];
            if (m_kind[t] == KIND_LOAD) begin
                ld_en  <= 1'b1;
                ld_tag <= t;
                draw(32, v);
                ld_data <= v;
            end else begin
                ex_en  <= 1'b1;
                ex_tag <= t;
                draw(32, v);
                ex_data <= v;
                draw(1, v);
                ex_taken <= v[0];
                draw(32, v);
                ex_target <= v;
            end
        end
        draw(5, v);
        rs1 <= reg_idx_t'(v);
        draw(5, v);
        rs2 <= reg_idx_t'(v);
    endtask

    initial begin
        lfsr = SEED;
        errors = 0;
        cycles = 0;
        retired = 0;
        stores = 0;
        flushes = 0;
        full_cycles = 0;
        rst_n = 1'b0;
        alloc_en = 1'b0;
        alloc_kind = KIND_ALU;
        alloc_rd = '0;
        alloc_pred_taken = 1'b0;
        ex_en = 1'b0;
        ex_tag = '0;
        ex_data = '0;
        ex_taken = 1'b0;
        ex_target = '0;
        ld_en = 1'b0;
        ld_tag = '0;
        ld_data = '0;
        rs1 = '0;
        rs2 = '0;
        for (int i = 0; i <= ENTRIES; i++) begin
            m_occ[i]  = 1'b0;
            m_done[i] = 1'b0;
        end
        for (int r = 0; r < 32; r++) begin
            shadow[r]   = '0;
            ren_busy[r] = 1'b0;
            ren_tag[r]  = '0;
        end
        m_wr = rob_tag_t'(1);
        m_flush = 1'b0;
        m_redirect = '0;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_outputs();

        while (retired < N_OPS && cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
            drive_inputs();
            @(negedge clk);
            check_outputs();
            update_model();
        end

        if (cycles >= CYCLE_LIMIT) begin
            errors++;
            $display("timeout: only %0d of %0d operations retired in %0d cycles",
                     retired, N_OPS, cycles);
        end
        if (stores == 0) begin
            errors++;
            $display("no store ever reached the head of the ROB");
        end
        if (flushes == 0) begin
            errors++;
            $display("no mispredicted branch ever caused a flush");
        end
        if (full_cycles == 0) begin
            errors++;
            $display("the ROB never filled up");
        end
        $display("errors=%0d retired=%0d stores=%0d flushes=%0d full_cycles=%0d cycles=%0d",
                 errors, retired, stores, flushes, full_cycles, cycles);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rob_sys.f
+incdir+hw
hw/rob_pkg.sv
hw/rob.sv
hw/rename_table.sv
hw/arch_regfile.sv
hw/rob_sys_top.sv
sim/rob_sys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module rob_sys_tb \
    -f rob_sys.f --Mdir obj_dir -o rob_sys_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/rob_sys_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi
exit 0
